//--- mips_pkg.sv
package mips_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int ALU_OP_W = 3;
    localparam int FWD_W    = 2;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [FWD_W-1:0] FWD_REG = 2'd0; // Value read in decode
    localparam logic [FWD_W-1:0] FWD_MEM = 2'd1; // EX/MEM ALU result
    localparam logic [FWD_W-1:0] FWD_WB  = 2'd2; // Write-back data

    // One instruction word in R and I format
    typedef union packed {
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [4:0]        shamt;
            logic [5:0]        funct;
        } r;
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [15:0]       imm;
        } i;
    } instr_t;

endpackage

//--- mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch import mips_pkg::*; #(
    parameter int IMEM_AW = 8
) (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_run,
    input  logic               i_stall,
    input  logic               i_flush,
    input  logic               i_br_taken,
    input  logic [DATA_W-1:0]  i_br_target,
    input  logic               i_id_halt,
    input  logic               i_imem_we,
    input  logic [IMEM_AW-1:0] i_imem_addr,
    input  logic [DATA_W-1:0]  i_imem_data,
    output instr_t             o_instr,
    output logic [DATA_W-1:0]  o_pc_next,
    output logic [DATA_W-1:0]  o_pc
);

    logic [DATA_W-1:0] imem [0:(1<<IMEM_AW)-1];
    logic [DATA_W-1:0] pc_plus4;
    logic              stop_q;
    logic              freeze;

    assign pc_plus4 = o_pc + DATA_W'(4);
    assign freeze   = stop_q || (i_id_halt && !i_flush); // Halt seen in IF/ID

    always_ff @(posedge i_clock) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_pc    <= '0;
            o_instr <= '0; // NOP
            stop_q  <= 1'b0;
        end else if (i_run) begin
            if (i_br_taken) begin
                o_pc <= i_br_target;
            end else if (!i_stall && !freeze) begin
                o_pc <= pc_plus4;
            end
            if (i_flush || (freeze && !i_stall)) begin
                o_instr <= '0;
            end else if (!i_stall) begin
                o_instr <= imem[o_pc[IMEM_AW+1:2]];
            end
            if (i_id_halt && !i_flush) begin
                stop_q <= 1'b1; // Never fetch past a halt
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run && !i_stall) begin
            o_pc_next <= pc_plus4;
        end
    end

endmodule

//--- mips_decode.sv
`timescale 1ns/1ps

module mips_decode import mips_pkg::*; (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_run,
    input  logic                i_flush,
    input  instr_t              i_instr,
    input  logic [DATA_W-1:0]   i_pc_next,
    input  logic                i_wb_en,
    input  logic [REG_AW-1:0]   i_wb_reg,
    input  logic [DATA_W-1:0]   i_wb_data,
    input  logic [REG_AW-1:0]   i_dbg_reg_addr,
    output logic [DATA_W-1:0]   o_dbg_reg_data,
    output logic                o_id_halt,
    output logic [REG_AW-1:0]   o_if_rs,
    output logic [REG_AW-1:0]   o_if_rt,
    output logic [ALU_OP_W-1:0] o_ex_alu_op,
    output logic                o_ex_alu_imm,
    output logic                o_ex_mem_read,
    output logic                o_ex_mem_write,
    output logic                o_ex_branch,
    output logic                o_ex_reg_write,
    output logic                o_ex_halt,
    output logic [DATA_W-1:0]   o_ex_a,
    output logic [DATA_W-1:0]   o_ex_b,
    output logic [DATA_W-1:0]   o_ex_imm,
    output logic [DATA_W-1:0]   o_ex_pc_next,
    output logic [REG_AW-1:0]   o_ex_rs,
    output logic [REG_AW-1:0]   o_ex_rt,
    output logic [REG_AW-1:0]   o_ex_dest
);

    logic [DATA_W-1:0]   regs [0:(1<<REG_AW)-1];
    logic [DATA_W-1:0]   rd_a;
    logic [DATA_W-1:0]   rd_b;
    logic [ALU_OP_W-1:0] alu_op;
    logic                alu_imm, mem_read, mem_write, branch, reg_write, halt;
    logic [REG_AW-1:0]   dest;

    assign o_id_halt      = (i_instr.r.opcode == OP_HALT);
    assign o_if_rs        = i_instr.r.rs;
    assign o_if_rt        = i_instr.i.rt;
    assign o_dbg_reg_data = regs[i_dbg_reg_addr];

    // Same-cycle write-back bypass
    assign rd_a = (i_wb_en && i_wb_reg == i_instr.r.rs) ? i_wb_data : regs[i_instr.r.rs];
    assign rd_b = (i_wb_en && i_wb_reg == i_instr.r.rt) ? i_wb_data : regs[i_instr.r.rt];

    always_comb begin
        alu_op    = ALU_ADD;
        alu_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        reg_write = 1'b0;
        halt      = 1'b0;
        dest      = i_instr.i.rt;
        case (i_instr.r.opcode)
            OP_RTYPE: begin
                dest      = i_instr.r.rd;
                reg_write = 1'b1;
                case (i_instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0; // Unknown funct becomes a bubble
                endcase
            end
            OP_ADDI: begin
                alu_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_imm   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_SW: begin
                alu_imm   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                alu_op = ALU_SUB;
                branch = 1'b1;
            end
            OP_HALT: halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int k = 0; k < (1 << REG_AW); k++) begin
                regs[k] <= '0;
            end
        end else if (i_run && i_wb_en) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_ex_mem_read  <= 1'b0;
            o_ex_mem_write <= 1'b0;
            o_ex_branch    <= 1'b0;
            o_ex_reg_write <= 1'b0;
            o_ex_halt      <= 1'b0;
            o_ex_rs        <= '0;
            o_ex_rt        <= '0;
            o_ex_dest      <= '0;
        end else if (i_run) begin
            o_ex_mem_read  <= !i_flush && mem_read;
            o_ex_mem_write <= !i_flush && mem_write;
            o_ex_branch    <= !i_flush && branch;
            o_ex_reg_write <= !i_flush && reg_write && (dest != '0); // r0 stays 0
            o_ex_halt      <= !i_flush && halt;
            o_ex_rs        <= i_instr.r.rs;
            o_ex_rt        <= i_instr.r.rt;
            o_ex_dest      <= dest;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_ex_alu_op  <= alu_op;
            o_ex_alu_imm <= alu_imm;
            o_ex_a       <= rd_a;
            o_ex_b       <= rd_b;
            o_ex_imm     <= {{(DATA_W-16){i_instr.i.imm[15]}}, i_instr.i.imm};
            o_ex_pc_next <= i_pc_next;
        end
    end

    // r0 write suppression must hold all the way to write-back
    a_no_r0_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_wb_en |-> i_wb_reg != '0);

endmodule

//--- mips_execute.sv
`timescale 1ns/1ps

module mips_execute import mips_pkg::*; (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_run,
    input  logic [ALU_OP_W-1:0] i_ex_alu_op,
    input  logic                i_ex_alu_imm,
    input  logic                i_ex_mem_read,
    input  logic                i_ex_mem_write,
    input  logic                i_ex_branch,
    input  logic                i_ex_reg_write,
    input  logic                i_ex_halt,
    input  logic [DATA_W-1:0]   i_ex_a,
    input  logic [DATA_W-1:0]   i_ex_b,
    input  logic [DATA_W-1:0]   i_ex_imm,
    input  logic [DATA_W-1:0]   i_ex_pc_next,
    input  logic [REG_AW-1:0]   i_ex_rs,
    input  logic [REG_AW-1:0]   i_ex_rt,
    input  logic [REG_AW-1:0]   i_ex_dest,
    input  logic [FWD_W-1:0]    i_fwd_a,
    input  logic [FWD_W-1:0]    i_fwd_b,
    input  logic [DATA_W-1:0]   i_wb_data,
    output logic                o_br_taken,
    output logic [DATA_W-1:0]   o_br_target,
    output logic [DATA_W-1:0]   o_mem_alu,
    output logic [DATA_W-1:0]   o_mem_store,
    output logic [REG_AW-1:0]   o_mem_dest,
    output logic                o_mem_reg_write,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mem_halt
);

    logic [DATA_W-1:0] op_a, op_b, alu_b, alu_y;

    function automatic logic [DATA_W-1:0] fwd_mux(input logic [FWD_W-1:0] sel,
                                                  input logic [DATA_W-1:0] reg_val);
        case (sel)
            FWD_MEM: return o_mem_alu;
            FWD_WB:  return i_wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a  = fwd_mux(i_fwd_a, i_ex_a);
        op_b  = fwd_mux(i_fwd_b, i_ex_b);
        alu_b = i_ex_alu_imm ? i_ex_imm : op_b;
        case (i_ex_alu_op)
            ALU_SUB: alu_y = op_a - alu_b;
            ALU_AND: alu_y = op_a & alu_b;
            ALU_OR:  alu_y = op_a | alu_b;
            ALU_SLT: alu_y = DATA_W'($signed(op_a) < $signed(alu_b));
            default: alu_y = op_a + alu_b;
        endcase
    end

    // Shadow slots are flushed by the hazard unit
    assign o_br_taken  = i_ex_branch && (alu_y == '0);
    assign o_br_target = i_ex_pc_next + {i_ex_imm[DATA_W-3:0], 2'b00};

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_mem_reg_write <= 1'b0;
            o_mem_read      <= 1'b0;
            o_mem_write     <= 1'b0;
            o_mem_halt      <= 1'b0;
            o_mem_dest      <= '0;
        end else if (i_run) begin
            o_mem_reg_write <= i_ex_reg_write;
            o_mem_read      <= i_ex_mem_read;
            o_mem_write     <= i_ex_mem_write;
            o_mem_halt      <= i_ex_halt;
            o_mem_dest      <= i_ex_dest;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_mem_alu   <= alu_y;
            o_mem_store <= op_b; // Forwarded store data
        end
    end

    a_fwd_code: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_fwd_a != 2'd3 && i_fwd_b != 2'd3);

    a_no_r0_fwd: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (i_ex_rs != '0 || i_fwd_a == FWD_REG) && (i_ex_rt != '0 || i_fwd_b == FWD_REG));

endmodule

//--- mips_memory.sv
`timescale 1ns/1ps

module mips_memory import mips_pkg::*; #(
    parameter int DMEM_AW = 8
) (
    input  logic              i_clock,
    input  logic              i_rst_n,
    input  logic              i_run,
    input  logic [DATA_W-1:0] i_mem_alu,
    input  logic [DATA_W-1:0] i_mem_store,
    input  logic [REG_AW-1:0] i_mem_dest,
    input  logic              i_mem_reg_write,
    input  logic              i_mem_read,
    input  logic              i_mem_write,
    input  logic              i_mem_halt,
    output logic              o_wb_en,
    output logic [REG_AW-1:0] o_wb_reg,
    output logic [DATA_W-1:0] o_wb_data,
    output logic [REG_AW-1:0] o_wb_dest,
    output logic              o_halt
);

    logic [DATA_W-1:0] dmem [0:(1<<DMEM_AW)-1];
    logic [DATA_W-1:0] load_word;

    assign load_word = dmem[i_mem_alu[DMEM_AW+1:2]];
    assign o_wb_reg  = o_wb_en ? o_wb_dest : '0; // Write port idles on r0

    always_ff @(posedge i_clock) begin
        if (i_run && i_mem_write) begin
            dmem[i_mem_alu[DMEM_AW+1:2]] <= i_mem_store;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_wb_en   <= 1'b0;
            o_wb_dest <= '0;
            o_halt    <= 1'b0;
        end else if (i_run) begin
            o_wb_en   <= i_mem_reg_write;
            o_wb_dest <= i_mem_dest;
            if (i_mem_halt) begin
                o_halt <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_run) begin
            o_wb_data <= i_mem_read ? load_word : i_mem_alu;
        end
    end

    a_rd_wr_excl: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_mem_read && i_mem_write));

endmodule

//--- mips_hazard.sv
`timescale 1ns/1ps

module mips_hazard import mips_pkg::*; (
    input  logic [REG_AW-1:0] i_if_rs,
    input  logic [REG_AW-1:0] i_if_rt,
    input  logic [REG_AW-1:0] i_ex_rs,
    input  logic [REG_AW-1:0] i_ex_rt,
    input  logic              i_ex_mem_read,
    input  logic              i_br_taken,
    input  logic [REG_AW-1:0] i_mem_dest,
    input  logic              i_mem_reg_write,
    input  logic [REG_AW-1:0] i_wb_dest,
    input  logic              i_wb_en,
    output logic [FWD_W-1:0]  o_fwd_a,
    output logic [FWD_W-1:0]  o_fwd_b,
    output logic              o_stall,
    output logic              o_flush_if,
    output logic              o_flush_id
);

    logic load_use;

    // Youngest producer wins
    function automatic logic [FWD_W-1:0] fwd_src(input logic [REG_AW-1:0] src);
        if (src == '0) begin
            return FWD_REG;
        end else if (i_mem_reg_write && i_mem_dest == src) begin
            return FWD_MEM;
        end else if (i_wb_en && i_wb_dest == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        o_fwd_a = fwd_src(i_ex_rs);
        o_fwd_b = fwd_src(i_ex_rt);
    end

    assign load_use   = i_ex_mem_read && (i_ex_rt == i_if_rs || i_ex_rt == i_if_rt);
    assign o_stall    = load_use && !i_br_taken; // Flush outranks stall
    assign o_flush_if = i_br_taken;
    assign o_flush_id = i_br_taken || load_use;

endmodule

//--- mips_pipeline.sv
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*; #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic               i_clock,
    input  logic               i_rst_n,
    input  logic               i_run,
    input  logic               i_imem_we,
    input  logic [IMEM_AW-1:0] i_imem_addr,
    input  logic [DATA_W-1:0]  i_imem_data,
    input  logic [REG_AW-1:0]  i_dbg_reg_addr,
    output logic               o_halt,
    output logic [DATA_W-1:0]  o_pc,
    output logic [DATA_W-1:0]  o_dbg_reg_data
);

    instr_t              id_instr;
    logic [DATA_W-1:0]   id_pc_next;
    logic                id_halt;
    logic [REG_AW-1:0]   if_rs, if_rt;
    logic [ALU_OP_W-1:0] ex_alu_op;
    logic                ex_alu_imm, ex_mem_read, ex_mem_write, ex_branch;
    logic                ex_reg_write, ex_halt;
    logic [DATA_W-1:0]   ex_a, ex_b, ex_imm, ex_pc_next;
    logic [REG_AW-1:0]   ex_rs, ex_rt, ex_dest;
    logic                br_taken;
    logic [DATA_W-1:0]   br_target;
    logic [DATA_W-1:0]   mem_alu, mem_store;
    logic [REG_AW-1:0]   mem_dest;
    logic                mem_reg_write, mem_read, mem_write, mem_halt;
    logic                wb_en;
    logic [REG_AW-1:0]   wb_reg, wb_dest;
    logic [DATA_W-1:0]   wb_data;
    logic [FWD_W-1:0]    fwd_a, fwd_b;
    logic                stall, flush_if, flush_id;

    mips_fetch #(
        .IMEM_AW(IMEM_AW)
    ) u_fetch (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_run       (i_run),
        .i_stall     (stall),
        .i_flush     (flush_if),
        .i_br_taken  (br_taken),
        .i_br_target (br_target),
        .i_id_halt   (id_halt),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_instr     (id_instr),
        .o_pc_next   (id_pc_next),
        .o_pc        (o_pc)
    );

    mips_decode u_decode (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_run          (i_run),
        .i_flush        (flush_id),
        .i_instr        (id_instr),
        .i_pc_next      (id_pc_next),
        .i_wb_en        (wb_en),
        .i_wb_reg       (wb_reg),
        .i_wb_data      (wb_data),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_id_halt      (id_halt),
        .o_if_rs        (if_rs),
        .o_if_rt        (if_rt),
        .o_ex_alu_op    (ex_alu_op),
        .o_ex_alu_imm   (ex_alu_imm),
        .o_ex_mem_read  (ex_mem_read),
        .o_ex_mem_write (ex_mem_write),
        .o_ex_branch    (ex_branch),
        .o_ex_reg_write (ex_reg_write),
        .o_ex_halt      (ex_halt),
        .o_ex_a         (ex_a),
        .o_ex_b         (ex_b),
        .o_ex_imm       (ex_imm),
        .o_ex_pc_next   (ex_pc_next),
        .o_ex_rs        (ex_rs),
        .o_ex_rt        (ex_rt),
        .o_ex_dest      (ex_dest)
    );

    mips_execute u_execute (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_run           (i_run),
        .i_ex_alu_op     (ex_alu_op),
        .i_ex_alu_imm    (ex_alu_imm),
        .i_ex_mem_read   (ex_mem_read),
        .i_ex_mem_write  (ex_mem_write),
        .i_ex_branch     (ex_branch),
        .i_ex_reg_write  (ex_reg_write),
        .i_ex_halt       (ex_halt),
        .i_ex_a          (ex_a),
        .i_ex_b          (ex_b),
        .i_ex_imm        (ex_imm),
        .i_ex_pc_next    (ex_pc_next),
        .i_ex_rs         (ex_rs),
        .i_ex_rt         (ex_rt),
        .i_ex_dest       (ex_dest),
        .i_fwd_a         (fwd_a),
        .i_fwd_b         (fwd_b),
        .i_wb_data       (wb_data),
        .o_br_taken      (br_taken),
        .o_br_target     (br_target),
        .o_mem_alu       (mem_alu),
        .o_mem_store     (mem_store),
        .o_mem_dest      (mem_dest),
        .o_mem_reg_write (mem_reg_write),
        .o_mem_read      (mem_read),
        .o_mem_write     (mem_write),
        .o_mem_halt      (mem_halt)
    );

    mips_memory #(
        .DMEM_AW(DMEM_AW)
    ) u_memory (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_run           (i_run),
        .i_mem_alu       (mem_alu),
        .i_mem_store     (mem_store),
        .i_mem_dest      (mem_dest),
        .i_mem_reg_write (mem_reg_write),
        .i_mem_read      (mem_read),
        .i_mem_write     (mem_write),
        .i_mem_halt      (mem_halt),
        .o_wb_en         (wb_en),
        .o_wb_reg        (wb_reg),
        .o_wb_data       (wb_data),
        .o_wb_dest       (wb_dest),
        .o_halt          (o_halt)
    );

    mips_hazard u_hazard (
        .i_if_rs         (if_rs),
        .i_if_rt         (if_rt),
        .i_ex_rs         (ex_rs),
        .i_ex_rt         (ex_rt),
        .i_ex_mem_read   (ex_mem_read),
        .i_br_taken      (br_taken),
        .i_mem_dest      (mem_dest),
        .i_mem_reg_write (mem_reg_write),
        .i_wb_dest       (wb_dest),
        .i_wb_en         (wb_en),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b),
        .o_stall         (stall),
        .o_flush_if      (flush_if),
        .o_flush_id      (flush_id)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
    end

endmodule

//--- tb_mips_pipeline.sv
`timescale 1ns/1ps

module tb_mips_pipeline
    import mips_pkg::*;
();

    localparam int IMEM_AW      = 8;
    localparam int DMEM_AW      = 8;
    localparam int PAT_AW       = 7;
    localparam int HALT_TIMEOUT = 500;
    localparam int HOLD_CYCLES  = 10;

    logic               i_clock;
    logic               i_rst_n;
    logic               i_run;
    logic               i_imem_we;
    logic [IMEM_AW-1:0] i_imem_addr;
    logic [DATA_W-1:0]  i_imem_data;
    logic [REG_AW-1:0]  i_dbg_reg_addr;
    logic               o_halt;
    logic [DATA_W-1:0]  o_pc;
    logic [DATA_W-1:0]  o_dbg_reg_data;

    logic [DATA_W-1:0]  pat [0:(1<<PAT_AW)-1];
    logic [DATA_W-1:0]  exp_pc;
    int                 prog_len;
    int                 pair_cnt;
    int                 pair_base;
    int                 cycles;

    tb_clock_gen #(.PERIOD_NS(8.0)) u_clock_gen (.o_clock(i_clock));

    mips_pipeline #(
        .IMEM_AW(IMEM_AW),
        .DMEM_AW(DMEM_AW)
    ) dut (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_run          (i_run),
        .i_imem_we      (i_imem_we),
        .i_imem_addr    (i_imem_addr),
        .i_imem_data    (i_imem_data),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_halt         (o_halt),
        .o_pc           (o_pc),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    function automatic logic [DATA_W-1:0] pattern_word(input int idx);
        return pat[PAT_AW'(idx)];
    endfunction

    task automatic next_cycle();
        @(posedge i_clock);
        #1; // Inputs change just after the edge
    endtask

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] expected);
        if (got !== expected) begin
            $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_reg(input int idx, input logic [DATA_W-1:0] expected);
        next_cycle();
        i_dbg_reg_addr = REG_AW'(idx);
        #2; // Debug port is combinational
        check_value($sformatf("o_dbg_reg_data (r%0d)", idx), o_dbg_reg_data, expected);
    endtask

    initial begin
        i_rst_n        = 1'b0;
        i_run          = 1'b0;
        i_imem_we      = 1'b0;
        i_imem_addr    = '0;
        i_imem_data    = '0;
        i_dbg_reg_addr = '0;

        $readmemh("mips_patterns.hex", pat);
        if ($isunknown(pattern_word(0)) || pattern_word(0) == '0 ||
            pattern_word(0) > DATA_W'(1 << IMEM_AW)) begin
            $display("Pattern file mips_patterns.hex is missing or has a bad program length");
            abort_run();
        end
        prog_len  = int'(pattern_word(0));
        exp_pc    = pattern_word(prog_len + 1);
        pair_cnt  = int'(pattern_word(prog_len + 2));
        pair_base = prog_len + 3;
        if (pair_base + 2 * pair_cnt > (1 << PAT_AW)) begin
            $display("Pattern file mips_patterns.hex holds more pairs than fit");
            abort_run();
        end

        repeat (2) next_cycle();
        i_rst_n = 1'b1;
        check_value("o_halt", DATA_W'(o_halt), '0);
        check_value("o_pc", o_pc, '0);
        for (int r = 0; r < (1 << REG_AW); r++) begin
            check_reg(r, '0);
        end

        // Program load with the pipeline stopped
        for (int k = 0; k < prog_len; k++) begin
            i_imem_we   = 1'b1;
            i_imem_addr = IMEM_AW'(k);
            i_imem_data = pattern_word(k + 1);
            next_cycle();
            check_value("o_pc", o_pc, '0);
        end
        i_imem_we = 1'b0;
        repeat (3) begin
            next_cycle();
            check_value("o_pc", o_pc, '0);
        end

        i_run  = 1'b1;
        cycles = 0;
        while (!o_halt) begin
            if (cycles >= HALT_TIMEOUT) begin
                $display("Timeout: o_halt did not rise within %0d cycles", HALT_TIMEOUT);
                abort_run();
            end
            next_cycle();
            cycles++;
        end

        repeat (HOLD_CYCLES) begin
            next_cycle();
            check_value("o_halt", DATA_W'(o_halt), DATA_W'(1));
            check_value("o_pc", o_pc, exp_pc);
        end

        for (int k = 0; k < pair_cnt; k++) begin
            check_reg(int'(pattern_word(pair_base + 2 * k)), pattern_word(pair_base + 2 * k + 1));
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- mips_patterns.hex
// Program length, program words, final PC, pair count,
// then pairs of register index and expected value
00000017
20010005 // 00 addi r1, r0, 5
20220003 // 04 addi r2, r1, 3
00221821 // 08 addu r3, r1, r2
00612023 // 0c subu r4, r3, r1
00832824 // 10 and  r5, r4, r3
00a13025 // 14 or   r6, r5, r1
0026382a // 18 slt  r7, r1, r6
2008fff9 // 1c addi r8, r0, -7
0107482a // 20 slt  r9, r8, r7
00c65021 // 24 addu r10, r6, r6
ac0a0010 // 28 sw   r10, 16(r0)
8c0b0010 // 2c lw   r11, 16(r0)
01616021 // 30 addu r12, r11, r1, load-use
10220002 // 34 beq  r1, r2, +2 not taken
200d0011 // 38 addi r13, r0, 0x11
11ad0002 // 3c beq  r13, r13, +2 taken
200e0022 // 40 addi r14, r0, 0x22 skipped
200f0033 // 44 addi r15, r0, 0x33 skipped
20100044 // 48 addi r16, r0, 0x44
20000055 // 4c addi r0, r0, 0x55
fc000000 // 50 halt
20110066 // 54 addi r17, r0, 0x66 never runs
20120077 // 58 addi r18, r0, 0x77 never runs
00000054 // Final PC
00000013 // Pair count
00 00000000  01 00000005  02 00000008  03 0000000d
04 00000008  05 00000008  06 0000000d  07 00000001
08 fffffff9  09 00000001  0a 0000001a  0b 0000001a
0c 0000001f  0d 00000011  0e 00000000  0f 00000000
10 00000044  11 00000000  12 00000000

//--- src.f
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_hazard.sv
mips_pipeline.sv
tb_clock_gen.sv
tb_mips_pipeline.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_pipeline
RTL_TOP   ?= mips_pipeline
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert
FILELIST  ?= src.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build mips_patterns.hex
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
